// ==== dv/ecc_cases.txt ====
# hot_idx hot_val gap_mode line_code col_code (hex)
# all other bytes of the page are zero
00 01 0 d555 d5
7f 80 0 eaaa ea
05 03 1 c000 c3
40 ff 2 c000 c0
2a 10 0 d999 e5
55 07 1 e666 da
01 00 0 c000 c0
3c a4 2 daa5 d5
7e 40 1 eaa9 e9
11 e0 0 d656 e5
63 08 2 e95a da
08 0e 0 d595 d5
20 5b 1 d955 d5
4b c1 2 e59a d6

// ==== all.f ====
source/ecc_pkg.sv
source/column_parity_acc.sv
source/line_parity_acc.sv
source/ecc_fold.sv
source/ecc_byte_streamer.sv
source/nand_ecc_gen.sv
dv/nand_ecc_gen_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f all.f --top-module nand_ecc_gen_tb -o sim
./obj_dir/sim | tee sim.log
if grep -q -F "Test completed successfully" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation did not pass"
exit 1

// ==== dv/nand_ecc_gen_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module nand_ecc_gen_tb;

	import ecc_pkg::*;

	localparam int clk_half     = 10;
	localparam int reset_cycles = 5;
	localparam int idle_timeout = 64;

	logic              clk;
	logic              rst;
	page_byte_t        page_byte;
	logic              byte_valid;
	ecc_code_t         ecc;
	logic              ecc_done;
	logic [byte_w-1:0] ecc_byte;
	logic              ecc_byte_valid;

	integer seed;
	int     err_count = 0;
	int     fail_count = 0;
	int     cyc = 0;

	logic [byte_w-1:0] page_data [page_bytes];

	// codes still owed by the DUT, with the cycle of their ecc_done
	ecc_code_t exp_code_q [$];
	int        exp_cyc_q [$];

	ecc_code_t stream_code;
	int        stream_left = 0;

	nand_ecc_gen u_nand_ecc_gen (
		.clk            (clk),
		.rst            (rst),
		.page_byte      (page_byte),
		.byte_valid     (byte_valid),
		.ecc            (ecc),
		.ecc_done       (ecc_done),
		.ecc_byte       (ecc_byte),
		.ecc_byte_valid (ecc_byte_valid)
	);

	initial clk = 1'b0;
	always #clk_half clk = ~clk;

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	function automatic ecc_code_t fold_model(input logic [byte_w-1:0] data [page_bytes]);
		ecc_code_t             code;
		logic [byte_w-1:0]     col_sum;
		logic [idx_w-1:0]      pos;
		logic [col_addr_w-1:0] bit_pos;
		code    = '0;
		col_sum = '0;
		for (int p = 0; p < page_bytes; p++)
		begin
			pos     = p[idx_w-1:0];
			col_sum = col_sum ^ data[pos];
			// an odd byte flips one line bit per index bit
			if (^data[pos])
			begin
				for (int b = 0; b < idx_w; b++)
				begin
					code.line = code.line ^ (line_code_w'(1) << (2 * b + ((p >> b) & 1)));
				end
			end
		end
		for (int i = 0; i < byte_w; i++)
		begin
			bit_pos = i[col_addr_w-1:0];
			if (col_sum[bit_pos])
			begin
				for (int b = 0; b < col_addr_w; b++)
				begin
					code.col = code.col ^ (col_code_w'(1) << (2 * b + ((i >> b) & 1)));
				end
			end
		end
		code.line[line_code_w-1:2*idx_w]   = '1;
		code.col[col_code_w-1:2*col_addr_w] = '1;
		return code;
	endfunction

	// spare-area order is line low, line high, column
	function automatic logic [byte_w-1:0] stream_byte(input ecc_code_t code, input int k);
		if (k == 0)
			return code.line[byte_w-1:0];
		else if (k == 1)
			return code.line[2*byte_w-1:byte_w];
		else
			return code.col;
	endfunction

	task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (exp !== act)
		begin
			err_count++;
			$display("ERR %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	//////////////////////////////////////////////////
	// output monitor
	//////////////////////////////////////////////////

	always @(negedge clk)
	begin
		cyc = cyc + 1;
		if (stream_left > 0)
		begin
			if (!ecc_byte_valid)
			begin
				fail_count++;
				$display("%0t: code byte stream stopped early", $time);
			end
			else
			begin
				check_value("ecc_byte", 16'(stream_byte(stream_code, 3 - stream_left)),
					16'(ecc_byte));
			end
			stream_left--;
		end
		else if (ecc_byte_valid)
		begin
			fail_count++;
			$display("%0t: ecc_byte_valid high with no code to send", $time);
		end
		if (ecc_done)
		begin
			if (exp_code_q.size() == 0)
			begin
				fail_count++;
				$display("%0t: ecc_done pulsed with no page finished", $time);
			end
			else
			begin
				if (cyc != exp_cyc_q[0])
				begin
					err_count++;
					$display("ERR %0t ecc_done cycle expected %0d got %0d", $time,
						exp_cyc_q[0], cyc);
				end
				check_value("ecc.line", exp_code_q[0].line, ecc.line);
				check_value("ecc.col", 16'(exp_code_q[0].col), 16'(ecc.col));
				stream_code = exp_code_q[0];
				stream_left = ecc_bytes;
				void'(exp_code_q.pop_front());
				void'(exp_cyc_q.pop_front());
			end
		end
		else if (exp_cyc_q.size() != 0 && cyc > exp_cyc_q[0])
		begin
			fail_count++;
			$display("%0t: ecc_done did not come after the last page byte", $time);
			void'(exp_code_q.pop_front());
			void'(exp_cyc_q.pop_front());
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	task automatic fill_random();
		logic [31:0]      r;
		logic [idx_w-1:0] pos;
		for (int p = 0; p < page_bytes; p++)
		begin
			pos           = p[idx_w-1:0];
			r             = $random(seed);
			page_data[pos] = r[byte_w-1:0];
		end
	endtask

	// gap mode picks no idle, one idle or 0 to 3 random idle cycles
	task automatic send_bytes(input int count, input int gap_mode, input ecc_code_t exp_code);
		logic [31:0]      r;
		logic [idx_w-1:0] pos;
		int               gap;
		for (int p = 0; p < count; p++)
		begin
			pos = p[idx_w-1:0];
			@(posedge clk);
			page_byte.data <= page_data[pos];
			page_byte.idx  <= pos;
			byte_valid     <= 1'b1;
			if (p == page_bytes - 1)
			begin
				// accepted on the next edge, done two edges later
				exp_code_q.push_back(exp_code);
				exp_cyc_q.push_back(cyc + 3);
			end
			gap = 0;
			if (gap_mode == 1)
			begin
				gap = 1;
			end
			else if (gap_mode == 2)
			begin
				r   = $random(seed);
				gap = int'(r[1:0]);
			end
			repeat (gap)
			begin
				@(posedge clk);
				byte_valid <= 1'b0;
			end
		end
	endtask

	task automatic wait_idle();
		int n;
		@(posedge clk);
		byte_valid <= 1'b0;
		n = 0;
		while ((exp_code_q.size() != 0 || stream_left != 0) && n < idle_timeout)
		begin
			@(posedge clk);
			n++;
		end
		if (exp_code_q.size() != 0 || stream_left != 0)
		begin
			fail_count++;
			$display("%0t: timed out waiting for the code and its byte stream", $time);
			exp_code_q.delete();
			exp_cyc_q.delete();
		end
	endtask

	task automatic check_after_reset(input int cycles);
		for (int n = 0; n < cycles; n++)
		begin
			@(negedge clk);
			check_value("ecc.line", 16'h0000, ecc.line);
			check_value("ecc.col", 16'h0000, 16'(ecc.col));
		end
	endtask

	task automatic run_case_file();
		int               fd;
		int               n;
		string            text;
		int               hot_idx;
		int               hot_val;
		int               gap_mode;
		int               exp_line;
		int               exp_col;
		ecc_code_t        exp_code;
		logic [idx_w-1:0] hot_pos;
		fd = $fopen("dv/ecc_cases.txt", "r");
		if (fd == 0)
		begin
			fail_count++;
			$display("could not open dv/ecc_cases.txt");
			return;
		end
		while (!$feof(fd))
		begin
			n = $fgets(text, fd);
			n = $sscanf(text, "%h %h %h %h %h", hot_idx, hot_val, gap_mode, exp_line, exp_col);
			if (n == 5)
			begin
				for (int p = 0; p < page_bytes; p++)
					page_data[p[idx_w-1:0]] = '0;
				hot_pos            = hot_idx[idx_w-1:0];
				page_data[hot_pos] = hot_val[byte_w-1:0];
				exp_code.line      = exp_line[line_code_w-1:0];
				exp_code.col       = exp_col[col_code_w-1:0];
				send_bytes(page_bytes, gap_mode, exp_code);
				wait_idle();
			end
		end
		$fclose(fd);
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial
	begin
		seed       = 32'h797893b2;
		rst        = 1'b1;
		byte_valid = 1'b0;
		page_byte  = '0;
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;

		check_after_reset(8);
		run_case_file();

		for (int m = 0; m < 3; m++)
		begin
			fill_random();
			send_bytes(page_bytes, m, fold_model(page_data));
			wait_idle();
		end

		// page cut off at index 63 and then two full pages back to back
		fill_random();
		send_bytes(64, 0, '0);
		fill_random();
		send_bytes(page_bytes, 0, fold_model(page_data));
		fill_random();
		send_bytes(page_bytes, 0, fold_model(page_data));
		wait_idle();

		$display("value errors: %0d, other failures: %0d", err_count, fail_count);
		if (err_count == 0 && fail_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/nand_ecc_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module nand_ecc_gen (
	input  logic                      clk,
	input  logic                      rst,
	input  ecc_pkg::page_byte_t       page_byte,
	input  logic                      byte_valid,
	output ecc_pkg::ecc_code_t        ecc,
	output logic                      ecc_done,
	output logic [ecc_pkg::byte_w-1:0] ecc_byte,
	output logic                      ecc_byte_valid
);

	import ecc_pkg::*;

	logic [byte_w-1:0]     col_par;
	logic [page_bytes-1:0] line_par;
	logic                  page_done;

	//////////////////////////////////////////////////
	// running parities
	//////////////////////////////////////////////////

	column_parity_acc u_column_parity_acc (
		.clk        (clk),
		.rst        (rst),
		.page_byte  (page_byte),
		.byte_valid (byte_valid),
		.col_par    (col_par)
	);

	line_parity_acc u_line_parity_acc (
		.clk        (clk),
		.rst        (rst),
		.page_byte  (page_byte),
		.byte_valid (byte_valid),
		.line_par   (line_par),
		.page_done  (page_done)
	);

	//////////////////////////////////////////////////
	// code and spare-area stream
	//////////////////////////////////////////////////

	ecc_fold u_ecc_fold (
		.clk       (clk),
		.rst       (rst),
		.col_par   (col_par),
		.line_par  (line_par),
		.page_done (page_done),
		.ecc       (ecc),
		.ecc_done  (ecc_done)
	);

	ecc_byte_streamer u_ecc_byte_streamer (
		.clk            (clk),
		.rst            (rst),
		.ecc            (ecc),
		.ecc_done       (ecc_done),
		.ecc_byte       (ecc_byte),
		.ecc_byte_valid (ecc_byte_valid)
	);

endmodule

`default_nettype wire

// ==== source/ecc_byte_streamer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_byte_streamer (
	input  logic                      clk,
	input  logic                      rst,
	input  ecc_pkg::ecc_code_t        ecc,
	input  logic                      ecc_done,
	output logic [ecc_pkg::byte_w-1:0] ecc_byte,
	output logic                      ecc_byte_valid
);

	import ecc_pkg::*;

	// zero when idle, else position of the next byte
	logic [1:0]        byte_cnt;
	logic [1:0]        pos;
	logic              load;
	logic [byte_w-1:0] pos_byte;

	// a fresh code always starts at line low
	assign pos  = ecc_done ? 2'd0 : byte_cnt;
	assign load = ecc_done || (byte_cnt != 2'd0);

	always_comb
	begin
		case (pos)
			2'd0:    pos_byte = ecc.line[byte_w-1:0];
			2'd1:    pos_byte = ecc.line[line_code_w-1:byte_w];
			default: pos_byte = ecc.col;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			byte_cnt       <= 2'd0;
			ecc_byte_valid <= 1'b0;
		end
		else if (ecc_done)
		begin
			byte_cnt       <= 2'd1;
			ecc_byte_valid <= 1'b1;
		end
		else if (byte_cnt != 2'd0)
		begin
			ecc_byte_valid <= 1'b1;
			if (byte_cnt == 2'(ecc_bytes - 1))
				byte_cnt <= 2'd0;
			else
				byte_cnt <= byte_cnt + 2'd1;
		end
		else
		begin
			ecc_byte_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
			ecc_byte <= pos_byte;
	end

endmodule

`default_nettype wire

// ==== source/ecc_fold.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_fold (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [ecc_pkg::byte_w-1:0]     col_par,
	input  logic [ecc_pkg::page_bytes-1:0] line_par,
	input  logic                          page_done,
	output ecc_pkg::ecc_code_t            ecc,
	output logic                          ecc_done
);

	import ecc_pkg::*;

	logic [col_code_w-1:0]  col_code;
	logic [line_code_w-1:0] line_code;

	//////////////////////////////////////////////////
	// column code
	//////////////////////////////////////////////////

	// even bit takes positions with bit b clear, odd bit with bit b set
	always_comb
	begin
		col_code = '0;
		for (int b = 0; b < col_addr_w; b++)
		begin
			for (int i = 0; i < byte_w; i++)
			begin
				if (i[b])
				begin
					col_code[2*b+1] = col_code[2*b+1] ^ col_par[i];
				end
				else
				begin
					col_code[2*b] = col_code[2*b] ^ col_par[i];
				end
			end
		end
		// unused top bits
		col_code[col_code_w-1:2*col_addr_w] = '1;
	end

	//////////////////////////////////////////////////
	// line code
	//////////////////////////////////////////////////

	always_comb
	begin
		line_code = '0;
		for (int b = 0; b < idx_w; b++)
		begin
			for (int i = 0; i < page_bytes; i++)
			begin
				if (i[b])
				begin
					line_code[2*b+1] = line_code[2*b+1] ^ line_par[i];
				end
				else
				begin
					line_code[2*b] = line_code[2*b] ^ line_par[i];
				end
			end
		end
		line_code[line_code_w-1:2*idx_w] = '1;
	end

	//////////////////////////////////////////////////
	// code register
	//////////////////////////////////////////////////

	// held until the next page completes
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			ecc <= '0;
		end
		else if (page_done)
		begin
			ecc.line <= line_code;
			ecc.col  <= col_code;
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			ecc_done <= 1'b0;
		end
		else
		begin
			ecc_done <= page_done;
		end
	end

endmodule

`default_nettype wire

// ==== source/line_parity_acc.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_parity_acc (
	input  logic                          clk,
	input  logic                          rst,
	input  ecc_pkg::page_byte_t           page_byte,
	input  logic                          byte_valid,
	output logic [ecc_pkg::page_bytes-1:0] line_par,
	output logic                          page_done
);

	import ecc_pkg::*;

	logic byte_par;
	logic last_byte;

	assign byte_par  = ^page_byte.data;
	assign last_byte = (page_byte.idx == idx_w'(page_bytes - 1));

	//////////////////////////////////////////////////
	// one parity bit per byte index
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			line_par <= '0;
		end
		else if (byte_valid)
		begin
			// each index is written exactly once per page
			line_par[page_byte.idx] <= byte_par;
		end
	end

	//////////////////////////////////////////////////
	// page end
	//////////////////////////////////////////////////

	// high in the cycle after the last byte is taken
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			page_done <= 1'b0;
		end
		else
		begin
			page_done <= byte_valid && last_byte;
		end
	end

endmodule

`default_nettype wire

// ==== source/column_parity_acc.sv ====
`timescale 1ns/1ps
`default_nettype none

module column_parity_acc (
	input  logic                      clk,
	input  logic                      rst,
	input  ecc_pkg::page_byte_t       page_byte,
	input  logic                      byte_valid,
	output logic [ecc_pkg::byte_w-1:0] col_par
);

	logic page_start;

	// index zero opens a new page
	assign page_start = (page_byte.idx == '0);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			col_par <= '0;
		end
		else if (byte_valid)
		begin
			if (page_start)
			begin
				col_par <= page_byte.data;
			end
			else
			begin
				// bitwise parity over all bytes so far
				col_par <= col_par ^ page_byte.data;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/ecc_pkg.sv ====
`default_nettype none

package ecc_pkg;

	//////////////////////////////////////////////////
	// page geometry
	//////////////////////////////////////////////////

	// one page of the spare-area code
	localparam int unsigned page_bytes = 128;
	localparam int unsigned byte_w     = 8;

	// index of a byte within the page
	localparam int unsigned idx_w      = 7;

	// bit position inside a byte
	localparam int unsigned col_addr_w = 3;

	//////////////////////////////////////////////////
	// code layout
	//////////////////////////////////////////////////

	// two code bits per index bit and the top two padded with ones
	localparam int unsigned line_code_w = 16;
	localparam int unsigned col_code_w  = 8;

	// spare-area bytes in line low, line high, column order
	localparam int unsigned ecc_bytes   = 3;

	//////////////////////////////////////////////////
	// bundles
	//////////////////////////////////////////////////

	// page byte with its position
	typedef struct packed {
		logic [byte_w-1:0] data;
		logic [idx_w-1:0]  idx;
	} page_byte_t;

	// finished hamming code of one page
	typedef struct packed {
		logic [line_code_w-1:0] line;
		logic [col_code_w-1:0]  col;
	} ecc_code_t;

endpackage

`default_nettype wire
